/* hdl/fetchPkg.sv */
// fetch front end shared types, constants and trap codes.
`default_nettype none

package fetchPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // basic words
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // byte address, always a word here.
    typedef logic [31:0] addrT;
    // one rv32 instruction.
    typedef logic [31:0] insnT;

    // pc after reset.
    localparam addrT ResetPc = 32'h0000_0000;
    // mcause code for instruction access fault.
    localparam logic [3:0] InsnAccessFault = 4'd1;

    // trap record handed down the pipe.
    typedef struct packed {
        logic       valid;
        logic [3:0] cause;
        addrT       value;
    } trapInfoT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wishbone classic, read only
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // master to slave.
    typedef struct packed {
        logic cyc;
        logic stb;
        addrT adr;
    } wbReqT;

    // slave to master.
    typedef struct packed {
        insnT dat;
        logic ack;
        logic err;
    } wbRspT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage boundaries
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // what the next stage sees.
    typedef struct packed {
        logic     valid;
        addrT     pc;
        insnT     insn;
        trapInfoT trapInfo;
    } fetchOutT;

    // new pc request, doubles as flush.
    typedef struct packed {
        logic valid;
        addrT target;
    } redirectT;

endpackage

`default_nettype wire

/* hdl/pcSequencer.sv */
// program counter sequencer: holds the fetch pc, takes redirects, steps on accept.
`timescale 1ns/1ps
`default_nettype none

module pcSequencer (
    input  logic               clk,
    input  logic               rstN,
    input  fetchPkg::redirectT redirect,
    input  logic               accept,
    output fetchPkg::addrT     pc
);

    // next pc candidate.
    fetchPkg::addrT pcNext;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next pc select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // redirect wins over accept.
    // stall shows up here as accept low, so pc holds.
    always_comb begin
        pcNext = pc;
        if (redirect.valid) begin
            pcNext = redirect.target;
        end else if (accept) begin
            // one rv32 instruction, no compressed.
            pcNext = pc + 32'd4;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pc register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= fetchPkg::ResetPc;
        end else begin
            pc <= pcNext;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // redirect targets come from outside, so alignment is not a given.
    // the line fetcher and stage both assume the low bits are zero.
    pcAligned: assert property (
        @(posedge clk) disable iff (!rstN)
        pc[1:0] == 2'b00
    ) else $error("pcSequencer: pc %h not word aligned", pc);

endmodule

`default_nettype wire

/* hdl/lineFetcher.sv */
// one-line instruction buffer, filled over a Wishbone classic read master.
`timescale 1ns/1ps
`default_nettype none

module lineFetcher #(
    parameter int LineWords = 4
) (
    input  logic                           clk,
    input  logic                           rstN,
    input  fetchPkg::addrT                 pc,
    output fetchPkg::wbReqT                wbReq,
    input  fetchPkg::wbRspT                wbRsp,
    output fetchPkg::insnT [LineWords-1:0] line,
    output logic                           lineHit,
    output logic                           lineFault
);

    // word index, byte offset and tag widths.
    localparam int IdxW = $clog2(LineWords);
    localparam int OffW = IdxW + 2;
    localparam int TagW = 32 - OffW;

    typedef enum logic {
        Idle,
        Filling
    } stateT;

    stateT           state;
    logic [TagW-1:0] lineTag;
    logic [TagW-1:0] pcTag;
    logic            lineValid;
    // sticky err over the current fill.
    logic            faultAcc;
    logic [IdxW-1:0] wordCnt;
    logic            xferDone;
    logic            lastWord;
    logic            startFill;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // hit and handshake decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign pcTag     = pc[31:OffW];
    assign lineHit   = lineValid && (lineTag == pcTag);
    // err ends a transfer just like ack.
    assign xferDone  = (state == Filling) && (wbRsp.ack || wbRsp.err);
    assign lastWord  = (wordCnt == IdxW'(LineWords - 1));
    // mismatch seen while idle.
    assign startFill = (state == Idle) && !lineHit;

    // cyc and stb held for the whole fill.
    always_comb begin
        wbReq.cyc = (state == Filling);
        wbReq.stb = (state == Filling);
        wbReq.adr = {lineTag, wordCnt, 2'b00};
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fill state machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= Idle;
            lineValid <= 1'b0;
            lineFault <= 1'b0;
            faultAcc  <= 1'b0;
            wordCnt   <= '0;
        end else begin
            case (state)
                Idle: begin
                    if (startFill) begin
                        // old contents get overwritten.
                        state     <= Filling;
                        lineValid <= 1'b0;
                        faultAcc  <= 1'b0;
                        wordCnt   <= '0;
                    end
                end
                Filling: begin
                    // runs to the end even if pc moved away.
                    if (xferDone) begin
                        faultAcc <= faultAcc | wbRsp.err;
                        if (lastWord) begin
                            state     <= Idle;
                            lineValid <= 1'b1;
                            lineFault <= faultAcc | wbRsp.err;
                        end else begin
                            wordCnt <= wordCnt + 1'b1;
                        end
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // tag and words, gated by lineValid.
    always_ff @(posedge clk) begin
        if (startFill) begin
            lineTag <= pcTag;
        end
        if (xferDone) begin
            line[wordCnt] <= wbRsp.dat;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // classic rule: request frozen until the slave answers.
    wbHold: assert property (
        @(posedge clk) disable iff (!rstN)
        wbReq.stb && !(wbRsp.ack || wbRsp.err) |=> wbReq.stb && $stable(wbReq.adr)
    ) else $error("lineFetcher: request changed before ack or err");

    // slave must pick one answer.
    wbOneRsp: assert property (
        @(posedge clk) disable iff (!rstN)
        !(wbRsp.ack && wbRsp.err)
    ) else $error("lineFetcher: ack and err together");

endmodule

`default_nettype wire

/* hdl/fetchStage.sv */
// fetch stage: picks the pc's instruction from the line, registers it with trap info.
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
    parameter int LineWords = 4
) (
    input  logic                           clk,
    input  logic                           rstN,
    input  fetchPkg::addrT                 pc,
    input  fetchPkg::insnT [LineWords-1:0] line,
    input  logic                           lineHit,
    input  logic                           lineFault,
    input  logic                           stall,
    input  logic                           flush,
    output logic                           accept,
    output fetchPkg::fetchOutT             fetchOut
);

    localparam int IdxW = $clog2(LineWords);

    logic [IdxW-1:0]    index;
    fetchPkg::insnT     insn;
    fetchPkg::trapInfoT trapNext;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // line select and trap
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // word offset bits of pc.
    assign index  = pc[IdxW+1:2];
    assign insn   = line[index];
    // an instruction leaves this cycle.
    assign accept = lineHit && !stall && !flush;

    // faulted line: access fault, tval is pc.
    always_comb begin
        trapNext = '0;
        if (lineFault) begin
            trapNext.valid = 1'b1;
            trapNext.cause = fetchPkg::InsnAccessFault;
            trapNext.value = pc;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // flush beats stall; stall holds everything.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fetchOut <= '0;
        end else if (flush) begin
            fetchOut <= '0;
        end else if (!stall) begin
            // no hit means a bubble.
            fetchOut.valid    <= accept;
            fetchOut.pc       <= pc;
            fetchOut.insn     <= lineFault ? '0 : insn;
            fetchOut.trapInfo <= trapNext;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a faulted accept shows up next cycle as a trap with a zero word.
    faultOut: assert property (
        @(posedge clk) disable iff (!rstN)
        accept && lineFault |=>
            fetchOut.valid && fetchOut.trapInfo.valid && (fetchOut.insn == '0)
    ) else $error("fetchStage: faulted fetch without trap output");

endmodule

`default_nettype wire

/* hdl/fetchTop.sv */
// fetch front end top: pc sequencer, line fetcher and fetch stage.
`timescale 1ns/1ps
`default_nettype none

module fetchTop #(
    parameter int LineWords = 4
) (
    input  logic               clk,
    input  logic               rstN,
    input  fetchPkg::redirectT redirect,
    input  logic               stall,
    output fetchPkg::wbReqT    wbReq,
    input  fetchPkg::wbRspT    wbRsp,
    output fetchPkg::fetchOutT fetchOut
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // internal nets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    fetchPkg::addrT                 pc;
    fetchPkg::insnT [LineWords-1:0] line;
    logic                           lineHit;
    logic                           lineFault;
    logic                           accept;
    logic                           flush;

    // redirect kills the stage output.
    assign flush = redirect.valid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // blocks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    pcSequencer i_pcSequencer (
        .clk      (clk),
        .rstN     (rstN),
        .redirect (redirect),
        .accept   (accept),
        .pc       (pc)
    );

    lineFetcher #(
        .LineWords (LineWords)
    ) i_lineFetcher (
        .clk       (clk),
        .rstN      (rstN),
        .pc        (pc),
        .wbReq     (wbReq),
        .wbRsp     (wbRsp),
        .line      (line),
        .lineHit   (lineHit),
        .lineFault (lineFault)
    );

    fetchStage #(
        .LineWords (LineWords)
    ) i_fetchStage (
        .clk       (clk),
        .rstN      (rstN),
        .pc        (pc),
        .line      (line),
        .lineHit   (lineHit),
        .lineFault (lineFault),
        .stall     (stall),
        .flush     (flush),
        .accept    (accept),
        .fetchOut  (fetchOut)
    );

endmodule

`default_nettype wire

/* bench/fetchMemModel.sv */
// Wishbone classic read slave for the fetch testbench, with ack delay and an err window.
`timescale 1ns/1ps
`default_nettype none

module fetchMemModel (
    input  logic            clk,
    input  logic            rstN,
    input  fetchPkg::wbReqT wbReq,
    output fetchPkg::wbRspT wbRsp,
    input  logic [31:0]     image [0:255],
    input  fetchPkg::addrT  errLo,
    input  fetchPkg::addrT  errHi,
    input  logic [1:0]      ackDelay
);

    logic       busy;
    logic [1:0] waitCnt;
    logic       reqLive;
    logic       answer;
    logic       inErr;

    // request waiting, not the one being answered right now.
    assign reqLive = wbReq.cyc && wbReq.stb && !(wbRsp.ack || wbRsp.err);
    // delay is sampled when a request first shows up.
    assign answer  = reqLive && (busy ? (waitCnt == 2'd0) : (ackDelay == 2'd0));
    // inclusive byte window.
    assign inErr   = (wbReq.adr >= errLo) && (wbReq.adr <= errHi);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbRsp   <= '0;
            busy    <= 1'b0;
            waitCnt <= 2'd0;
        end else begin
            // one cycle pulse per transfer.
            wbRsp.ack <= answer && !inErr;
            wbRsp.err <= answer && inErr;
            wbRsp.dat <= (answer && !inErr) ? image[wbReq.adr[9:2]] : '0;
            if (answer) begin
                busy <= 1'b0;
            end else if (reqLive) begin
                if (busy) begin
                    waitCnt <= waitCnt - 2'd1;
                end else begin
                    busy    <= 1'b1;
                    waitCnt <= ackDelay - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bench/fetchTb.sv */
// testbench for the fetch front end: file driven steps, random stall and ack delay.
`timescale 1ns/1ps
`default_nettype none

module fetchTb;

    localparam int LineWords = 4;

    logic               clk;
    logic               rstN;
    logic               stall;
    logic [1:0]         ackDelay;
    fetchPkg::redirectT redirect;
    fetchPkg::wbReqT    wbReq;
    fetchPkg::wbRspT    wbRsp;
    fetchPkg::fetchOutT fetchOut;

    // file image, then error window and steps from word 256 on.
    logic [31:0]    vec [0:511];
    logic [31:0]    image [0:255];
    fetchPkg::addrT errLo;
    fetchPkg::addrT errHi;
    logic           vecLoaded = 1'b0;
    int             totalInsns = 0;
    logic [31:0]    seed = 32'hef7a_b0e0;

    fetchTop #(
        .LineWords (LineWords)
    ) i_fetchTop (
        .clk      (clk),
        .rstN     (rstN),
        .redirect (redirect),
        .stall    (stall),
        .wbReq    (wbReq),
        .wbRsp    (wbRsp),
        .fetchOut (fetchOut)
    );

    fetchMemModel i_fetchMemModel (
        .clk      (clk),
        .rstN     (rstN),
        .wbReq    (wbReq),
        .wbRsp    (wbRsp),
        .image    (image),
        .errLo    (errLo),
        .errHi    (errHi),
        .ackDelay (ackDelay)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // plain lcg step.
    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // default word for a word index, every bit of it matters.
    function automatic logic [31:0] fillWord(input logic [7:0] idx);
        return {idx, idx ^ 8'hc3, ~idx, 8'h13};
    endfunction

    function automatic logic inErrRange(input fetchPkg::addrT a);
        return (a >= errLo) && (a <= errHi);
    endfunction

    task automatic abortRun();
        $display("FAIL: see errors above");
        $fatal(1, "run aborted");
    endtask

    task automatic checkValue(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            abortRun();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : watchdog
        longint limitNs;
        wait (vecLoaded);
        // per instruction budget, plus a little for reset.
        limitNs = longint'(totalInsns) * (LineWords * 4 + 4) * 10 + 100;
        #(limitNs);
        $display("watchdog expired after %0d ns, fetch output stopped advancing", limitNs);
        abortRun();
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : mainFlow
        int                 stepCnt;
        int                 got;
        logic               inFlight;
        logic               flushEdge;
        logic               stallEdge;
        fetchPkg::addrT     expPc;
        fetchPkg::addrT     target;
        fetchPkg::trapInfoT expTrap;
        fetchPkg::fetchOutT held;

        rstN     = 1'b0;
        stall    = 1'b0;
        ackDelay = 2'd0;
        redirect = '0;
        for (int i = 0; i < 512; i++) begin
            vec[i] = (i < 256) ? fillWord(i[7:0]) : 32'd0;
        end
        $readmemh("bench/fetchVectors.mem", vec);
        for (int i = 0; i < 256; i++) begin
            image[i] = vec[i];
        end
        errLo   = vec[256];
        errHi   = vec[257];
        stepCnt = int'(vec[258]);
        if (stepCnt < 1 || stepCnt > 100) begin
            $display("vector file holds no usable step count");
            abortRun();
        end
        for (int s = 0; s < stepCnt; s++) begin
            totalInsns = totalInsns + int'(vec[260 + 2 * s]);
        end
        vecLoaded = 1'b1;

        // two reset edges, then outputs quiet right after release.
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue("fetchOut.valid", fetchOut.valid, 1'b0);
        checkValue("wbReq.cyc", wbReq.cyc, 1'b0);
        checkValue("wbReq.stb", wbReq.stb, 1'b0);

        // first step starts at the reset pc.
        expPc    = vec[259];
        held     = fetchOut;
        inFlight = 1'b0;
        target   = '0;
        for (int s = 0; s < stepCnt; s++) begin
            got = 0;
            if (s > 0) begin
                target   = vec[259 + 2 * s];
                inFlight = 1'b1;
            end
            while (inFlight || got < int'(vec[260 + 2 * s])) begin
                @(posedge clk);
                // what the DUT sees at this edge.
                flushEdge = redirect.valid;
                stallEdge = stall;
                seed      = nextRandom(seed);
                stall    <= (seed[31:30] == 2'b00);
                ackDelay <= seed[21:20];
                if (inFlight && !flushEdge) begin
                    redirect.valid  <= 1'b1;
                    redirect.target <= target;
                end else begin
                    redirect <= '0;
                end
                @(negedge clk);
                if (flushEdge) begin
                    // old path must be gone.
                    checkValue("fetchOut.valid", fetchOut.valid, 1'b0);
                    expPc    = target;
                    inFlight = 1'b0;
                    got      = 0;
                end else if (stallEdge) begin
                    checkValue("fetchOut", fetchOut, held);
                end else if (fetchOut.valid) begin
                    checkValue("fetchOut.pc", fetchOut.pc, expPc);
                    expTrap = '0;
                    if (inErrRange(expPc)) begin
                        expTrap.valid = 1'b1;
                        expTrap.cause = fetchPkg::InsnAccessFault;
                        expTrap.value = expPc;
                        checkValue("fetchOut.insn", fetchOut.insn, '0);
                    end else begin
                        checkValue("fetchOut.insn", fetchOut.insn, image[expPc[9:2]]);
                    end
                    checkValue("fetchOut.trapInfo", fetchOut.trapInfo, expTrap);
                    expPc = expPc + 32'd4;
                    got   = got + 1;
                end
                held = fetchOut;
            end
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hdl/fetchPkg.sv
hdl/pcSequencer.sv
hdl/lineFetcher.sv
hdl/fetchStage.sv
hdl/fetchTop.sv
bench/fetchMemModel.sv
bench/fetchTb.sv

/* Makefile */
# Verilator build for the fetch front end testbench.
# the run exits non-zero when the testbench stops with $fatal.

TOP = fetchTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* bench/fetchVectors.mem */
// @000: image words over the fill pattern. @100: err low, err high (byte, line aligned),
// step count, then per step: start pc (first is the reset pc) and instruction count.
@000
00500093
00a00113
002081b3
0000006f
@100
00000200
0000023f
00000004
00000000 00000014
00000100 0000000a
000001f8 0000000c
00000300 00000008
